// File: Bender.yml
package:
  name: pkt_buf

sources:
  - pkt_buf_pkg.sv
  - bram_1w1r.sv
  - pkt_wr_ctrl.sv
  - pkt_rd_ctrl.sv
  - pkt_buf_top.sv
  - target: simulation
    files:
      - tb_pkt_buf.sv

// File: bram_1w1r.sv
module bram_1w1r #(
  parameter int width    = 33,
  parameter int addr_w   = 6,
  parameter int depth    = 64,
  parameter int pipeline = 0    // 0 or 1, read latency is pipeline+1
) (
  input  logic              clk,

  // write port
  input  logic              wea,
  input  logic              ena,
  input  logic [addr_w-1:0] addra,
  input  logic [width-1:0]  da,

  // read port
  input  logic              enb,
  input  logic [addr_w-1:0] addrb,
  output logic [width-1:0]  qb
);

  // --------------------
  // storage
  // --------------------

  logic [width-1:0] ram [depth];

  logic [width-1:0] rd_word;   // first read register
  logic [width-1:0] rd_word_q; // optional output stage

  // port A write, needs both enable and write strobe
  always_ff @(posedge clk)
  begin
    if (ena && wea)
    begin
      ram[addra] <= da;
    end
  end

  // --------------------
  // read path
  // --------------------

  // read-first: a same-cycle write to addrb returns the old word
  always_ff @(posedge clk)
  begin
    if (enb)
    begin
      rd_word <= ram[addrb]; // holds its value while enb low
    end
  end

  // second stage follows the first every cycle
  // once enb drops both stages settle on the same word
  always_ff @(posedge clk)
  begin
    rd_word_q <= rd_word;
  end

  // latency select
  assign qb = (pipeline != 0) ? rd_word_q : rd_word;

endmodule

// File: pkt_buf_pkg.sv
package pkt_buf_pkg;

  // --------------------
  // default sizes
  // --------------------

  // payload bits per word, last flag rides on top in the memory
  localparam int DATA_W = 32;

  // 64 words of storage by default
  localparam int ADDR_W = 6;

  // --------------------
  // write side FSM
  // --------------------

  typedef enum logic [1:0] {
    WR_IDLE    = 2'd0, // between packets
    WR_PKT     = 2'd1, // words going into the memory, not yet visible
    WR_DISCARD = 2'd2  // packet overflowed, eat words up to its last
  } wr_state_e;

  // --------------------
  // read side FSM
  // --------------------

  // only one read outstanding at a time, so three states are enough
  typedef enum logic [1:0] {
    RD_IDLE = 2'd0, // no read issued, output empty
    RD_WAIT = 2'd1, // read issued, counting memory latency
    RD_HOLD = 2'd2  // output word valid, waiting for pop
  } rd_state_e;

endpackage

// File: pkt_buf_top.sv
module pkt_buf_top #(
  parameter int data_w   = pkt_buf_pkg::DATA_W,
  parameter int addr_w   = pkt_buf_pkg::ADDR_W,
  parameter int pipeline = 1 // extra memory output stage
) (
  input  logic              clk,
  input  logic              reset,

  // write side
  input  logic              wr_en,
  input  logic [data_w-1:0] wr_data,
  input  logic              wr_last,
  input  logic              wr_abort,

  // read side
  output logic              rd_valid,
  output logic [data_w-1:0] rd_data,
  output logic              rd_last,
  input  logic              rd_en,

  // status
  output logic              pkt_drop
);

  // --------------------
  // internal wires
  // --------------------

  logic              mem_we;
  logic [addr_w-1:0] mem_addr;
  logic [data_w:0]   mem_din;    // payload plus last flag
  logic              mem_re;
  logic [addr_w-1:0] mem_raddr;
  logic [data_w:0]   mem_dout;
  logic [addr_w-1:0] commit_ptr; // writer to reader
  logic [addr_w-1:0] rd_ptr;     // reader to writer

  // writer, owns fullness and the commit point
  pkt_wr_ctrl #(
    .data_w (data_w),
    .addr_w (addr_w)
  ) u_wr_ctrl (
    .clk        (clk),
    .reset      (reset),
    .wr_en      (wr_en),
    .wr_last    (wr_last),
    .wr_abort   (wr_abort),
    .wr_data    (wr_data),
    .rd_ptr     (rd_ptr),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_din    (mem_din),
    .commit_ptr (commit_ptr),
    .pkt_drop   (pkt_drop)
  );

  // reader, sees only committed words
  pkt_rd_ctrl #(
    .data_w   (data_w),
    .addr_w   (addr_w),
    .pipeline (pipeline)
  ) u_rd_ctrl (
    .clk        (clk),
    .reset      (reset),
    .commit_ptr (commit_ptr),
    .rd_ptr     (rd_ptr),
    .mem_re     (mem_re),
    .mem_raddr  (mem_raddr),
    .mem_dout   (mem_dout),
    .rd_en      (rd_en),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .rd_last    (rd_last)
  );

  // full power-of-two depth, pointers wrap naturally
  bram_1w1r #(
    .width    (data_w + 1),
    .addr_w   (addr_w),
    .depth    (1 << addr_w),
    .pipeline (pipeline)
  ) u_mem (
    .clk   (clk),
    .wea   (mem_we),
    .ena   (mem_we), // port only active on a write
    .addra (mem_addr),
    .da    (mem_din),
    .enb   (mem_re),
    .addrb (mem_raddr),
    .qb    (mem_dout)
  );

endmodule

// File: pkt_rd_ctrl.sv
module pkt_rd_ctrl #(
  parameter int data_w   = 32,
  parameter int addr_w   = 6,
  parameter int pipeline = 0
) (
  input  logic              clk,
  input  logic              reset,

  // from write side
  input  logic [addr_w-1:0] commit_ptr,

  // back to write side, frees space on pop
  output logic [addr_w-1:0] rd_ptr,

  // memory read port
  output logic              mem_re,
  output logic [addr_w-1:0] mem_raddr,
  input  logic [data_w:0]   mem_dout,

  // packet output
  input  logic              rd_en,    // pop strobe
  output logic              rd_valid,
  output logic [data_w-1:0] rd_data,
  output logic              rd_last
);

  import pkt_buf_pkg::*;

  // memory latency is pipeline+1, counter starts at pipeline
  localparam logic [1:0] LAT_INIT = 2'(pipeline);

  rd_state_e         rd_state;
  logic [1:0]        lat_cnt;
  logic [addr_w-1:0] next_ptr;
  logic              pop;
  logic              issue_idle; // read from empty output
  logic              issue_pop;  // read of next word on the pop cycle
  logic              capture;

  // --------------------
  // read issue
  // --------------------

  assign next_ptr = rd_ptr + 1'b1;
  assign pop      = (rd_state == RD_HOLD) && rd_en; // pops ignored unless valid

  // committed data exists when pointers differ
  assign issue_idle = (rd_state == RD_IDLE) && (rd_ptr != commit_ptr);
  assign issue_pop  = pop && (next_ptr != commit_ptr);

  assign mem_re    = issue_idle || issue_pop;
  assign mem_raddr = pop ? next_ptr : rd_ptr; // on pop fetch the following word

  // last cycle of the wait, memory output now holds the word
  assign capture = (rd_state == RD_WAIT) && (lat_cnt == 2'd0);

  assign rd_valid = (rd_state == RD_HOLD);

  // --------------------
  // FSM
  // --------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_state <= RD_IDLE;
      rd_ptr   <= '0;
      lat_cnt  <= '0;
    end
    else
    begin
      case (rd_state)
        RD_IDLE:
        begin
          if (issue_idle)
          begin
            rd_state <= RD_WAIT;
            lat_cnt  <= LAT_INIT;
          end
        end
        RD_WAIT:
        begin
          if (capture)
          begin
            rd_state <= RD_HOLD;
          end
          else
          begin
            lat_cnt <= lat_cnt - 1'b1;
          end
        end
        RD_HOLD:
        begin
          if (pop)
          begin
            rd_ptr <= next_ptr; // word consumed, slot goes back to writer
            if (issue_pop)
            begin
              rd_state <= RD_WAIT; // next word already on its way
              lat_cnt  <= LAT_INIT;
            end
            else
            begin
              rd_state <= RD_IDLE;
            end
          end
        end
        default:
        begin
          rd_state <= RD_IDLE;
        end
      endcase
    end
  end

  // --------------------
  // held output word
  // --------------------

  // loaded once per read, stays put until the next capture
  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      rd_data <= mem_dout[data_w-1:0];
      rd_last <= mem_dout[data_w];
    end
  end

endmodule

// File: pkt_wr_ctrl.sv
module pkt_wr_ctrl #(
  parameter int data_w = 32,
  parameter int addr_w = 6
) (
  input  logic              clk,
  input  logic              reset,

  // packet input
  input  logic              wr_en,    // one word per strobe
  input  logic              wr_last,
  input  logic              wr_abort, // drop the packet in progress
  input  logic [data_w-1:0] wr_data,

  // oldest unread address from the read side
  input  logic [addr_w-1:0] rd_ptr,

  // memory write port
  output logic              mem_we,
  output logic [addr_w-1:0] mem_addr,
  output logic [data_w:0]   mem_din,  // {last, data}

  // end of newest committed packet
  output logic [addr_w-1:0] commit_ptr,
  output logic              pkt_drop  // one-cycle pulse per dropped packet
);

  import pkt_buf_pkg::*;

  wr_state_e         wr_state;
  logic [addr_w-1:0] wr_ptr;     // next address to fill
  logic [addr_w-1:0] wr_ptr_nxt;
  logic              full;
  logic              storing;    // not swallowing a dead packet
  logic              overflow;   // word offered with no room left

  // --------------------
  // fullness
  // --------------------

  // one slot kept empty so wr_ptr == rd_ptr always means empty
  assign wr_ptr_nxt = wr_ptr + 1'b1;
  assign full       = (wr_ptr_nxt == rd_ptr);

  assign storing  = (wr_state != WR_DISCARD);
  assign overflow = wr_en && !wr_abort && storing && full;

  // --------------------
  // memory side
  // --------------------

  assign mem_we   = wr_en && !wr_abort && storing && !full; // abort wins over a word
  assign mem_addr = wr_ptr;
  assign mem_din  = {wr_last, wr_data};                     // flag in top bit

  // --------------------
  // FSM and pointers
  // --------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_state   <= WR_IDLE;
      wr_ptr     <= '0;
      commit_ptr <= '0;
      pkt_drop   <= 1'b0;
    end
    else
    begin
      pkt_drop <= 1'b0; // default, pulse only

      if (wr_abort)
      begin
        // rewind to the last commit point, nothing partial survives
        wr_ptr   <= commit_ptr;
        wr_state <= WR_IDLE;
        pkt_drop <= storing; // a discard already flagged its own drop
      end
      else if (overflow)
      begin
        wr_ptr   <= commit_ptr;
        pkt_drop <= 1'b1;
        // an overflowing last word ends the packet right here
        wr_state <= wr_last ? WR_IDLE : WR_DISCARD;
      end
      else if (mem_we)
      begin
        wr_ptr <= wr_ptr_nxt;
        if (wr_last)
        begin
          commit_ptr <= wr_ptr_nxt; // packet visible to reader next cycle
          wr_state   <= WR_IDLE;
        end
        else
        begin
          wr_state <= WR_PKT;
        end
      end
      else if ((wr_state == WR_DISCARD) && wr_en && wr_last)
      begin
        wr_state <= WR_IDLE; // tail of the dead packet seen
      end
    end
  end

endmodule

// File: sim.f
pkt_buf_pkg.sv
bram_1w1r.sv
pkt_wr_ctrl.sv
pkt_rd_ctrl.sv
pkt_buf_top.sv
tb_pkt_buf.sv

// File: tb_pkt_buf.sv
module tb_pkt_buf;

  import pkt_buf_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int DEPTH       = 1 << ADDR_W;
  localparam int TOTAL_WORDS = 178;                       // word count of all tests
  localparam int WDOG_CYCLES = TOTAL_WORDS * 20 + 1000;  // 20 cycles per word plus margin

  logic              clk;
  logic              reset;
  logic              wr_en;
  logic [DATA_W-1:0] wr_data;
  logic              wr_last;
  logic              wr_abort;
  logic              rd_valid;
  logic [DATA_W-1:0] rd_data;
  logic              rd_last;
  logic              rd_en;
  logic              pkt_drop;

  logic [DATA_W:0] exp_q[$];  // {last, data} of committed packets, oldest first
  integer seed = 32'hc3d0fe8a;
  int exp_drops = 0;
  int drop_cnt = 0;
  int err_word = 0;
  int err_bit = 0;
  int err_count = 0;

  pkt_buf_top #(.data_w(DATA_W), .addr_w(ADDR_W), .pipeline(1)) u_dut (
    .clk(clk), .reset(reset), .wr_en(wr_en), .wr_data(wr_data), .wr_last(wr_last),
    .wr_abort(wr_abort), .rd_valid(rd_valid), .rd_data(rd_data), .rd_last(rd_last),
    .rd_en(rd_en), .pkt_drop(pkt_drop)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(negedge clk)
  begin
    if (pkt_drop === 1'b1)
      drop_cnt++; // one count per pulse cycle
  end

  // --------------------
  // compare tasks
  // --------------------

  task automatic check_word(input string name, input logic [DATA_W-1:0] got, exp);
    if (got !== exp)
    begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      err_word++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp)
    begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      err_bit++;
    end
  endtask

  task automatic expect_count(input string name, input int got, exp);
    if (got != exp)
    begin
      $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
      err_count++;
    end
  endtask

  // --------------------
  // drivers
  // --------------------

  // ten rising edges with reset high, released on a falling edge
  task automatic reset_dut();
    reset = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  endtask

  // one word for one cycle, caller is on a falling edge
  task automatic drive_word(input logic [DATA_W-1:0] data, input logic last);
    wr_en   = 1'b1;
    wr_data = data;
    wr_last = last;
    @(negedge clk);
    wr_en   = 1'b0;
    wr_last = 1'b0;
  endtask

  // pause_at > 0 idles the writer that many cycles before the last word
  task automatic send_pkt(input int len, input int pause_at = 0);
    logic [DATA_W-1:0] words[$];
    logic              fits;
    logic              last;
    fits = (len <= DEPTH - 1 - exp_q.size()); // free slots, one always kept empty
    for (int i = 0; i < len; i++)
    begin
      if (i == len - 1)
      begin
        repeat (pause_at)
        begin
          check_bit("rd_valid", rd_valid, 1'b0); // open packet stays hidden
          check_bit("pkt_drop", pkt_drop, 1'b0);
          @(negedge clk);
        end
      end
      words.push_back($random(seed));
      drive_word(words[i], i == len - 1);
    end
    foreach (words[i])
    begin
      last = (i == len - 1);
      if (fits)
        exp_q.push_back({last, words[i]});
    end
    if (!fits)
      exp_drops++; // overflow, whole packet gone
  endtask

  task automatic abort_pkt(input int len);
    repeat (len) drive_word($random(seed), 1'b0);
    wr_abort = 1'b1;
    @(negedge clk);
    wr_abort = 1'b0;
    exp_drops++;
  endtask

  // pops words up to and including the next last flag
  task automatic read_pkt(input int max_gap);
    logic [DATA_W:0] exp;
    logic            done;
    done = 1'b0;
    while (!done)
    begin
      while (rd_valid !== 1'b1) @(negedge clk);
      if (exp_q.size() == 0)
      begin
        $display("ERR %0t rd_valid high with no committed word expected", $time);
        err_bit++;
        done = 1'b1;
      end
      else
      begin
        exp = exp_q.pop_front();
        check_word("rd_data", rd_data, exp[DATA_W-1:0]);
        check_bit("rd_last", rd_last, exp[DATA_W]);
        repeat ($unsigned($random(seed)) % (max_gap + 1)) @(negedge clk); // pop gap
        rd_en = 1'b1;
        @(negedge clk);
        rd_en = 1'b0;
        done = exp[DATA_W];
      end
    end
  endtask

  // drain, then nothing else may show up
  task automatic read_all(input int max_gap);
    while (exp_q.size() > 0) read_pkt(max_gap);
    repeat (8) @(negedge clk);
    check_bit("rd_valid", rd_valid, 1'b0);
    expect_count("pkt_drop pulses", drop_cnt, exp_drops);
  endtask

  // --------------------
  // directed tests
  // --------------------

  task automatic idle_after_reset();
    repeat (4) @(negedge clk);
    check_bit("rd_valid", rd_valid, 1'b0);
    check_bit("pkt_drop", pkt_drop, 1'b0);
    send_pkt(6, 20);
    read_all(0);
  endtask

  task automatic order_of_packets();
    send_pkt(1);
    read_all(0);
    send_pkt(4); // back to back, no idle cycle
    send_pkt(9);
    send_pkt(2);
    send_pkt(17);
    read_all(0);
  endtask

  task automatic abort_between_packets();
    send_pkt(5);
    abort_pkt(6);
    send_pkt(8);
    read_all(2);
  endtask

  task automatic overflow_while_stalled();
    send_pkt(10);
    send_pkt(12);
    send_pkt(DEPTH); // longer than the whole buffer
    send_pkt(8);
    read_all(3);
  endtask

  task automatic hold_under_backpressure();
    send_pkt(7);
    send_pkt(3);
    send_pkt(16);
    while (rd_valid !== 1'b1) @(negedge clk);
    repeat (60)
    begin
      check_bit("rd_valid", rd_valid, 1'b1);
      check_word("rd_data", rd_data, exp_q[0][DATA_W-1:0]);
      check_bit("rd_last", rd_last, exp_q[0][DATA_W]);
      @(negedge clk);
    end
    read_all(5);
  endtask

  initial
  begin
    reset    = 1'b1;
    wr_en    = 1'b0;
    wr_data  = '0;
    wr_last  = 1'b0;
    wr_abort = 1'b0;
    rd_en    = 1'b0;
    reset_dut();
    idle_after_reset();
    order_of_packets();
    abort_between_packets();
    overflow_while_stalled();
    hold_under_backpressure();
    $display("errors: data %0d, flag %0d, count %0d", err_word, err_bit, err_count);
    if (err_word + err_bit + err_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("watchdog fired after %0d cycles, the DUT stopped delivering words", WDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule
